/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fsctl
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cfg_bus_if.sv */
`timescale 1ns/1ps

interface cfg_bus_if import fsctl_pkg::*; ();

	logic      wr_en;
	reg_idx_t  wr_idx;
	reg_data_t wr_data;
	reg_idx_t  rd_idx;

	// driven from the top level ports
	modport host (
		output wr_en,
		output wr_idx,
		output wr_data,
		output rd_idx
	);

	// register blocks decode their own indices
	modport target (
		input wr_en,
		input wr_idx,
		input wr_data,
		input rd_idx
	);

endinterface

/* cfg_read_port.sv */
`timescale 1ns/1ps

module cfg_read_port import fsctl_pkg::*; (
	input  logic      o_clk,
	input  logic      o_resetn,
	input  logic      i_rd_en,
	input  reg_idx_t  i_rd_idx,
	input  reg_data_t i_ctl_word,
	input  reg_data_t i_s1_word,
	input  reg_data_t i_s2_word,
	output reg_data_t o_rd_data
);

	// blocks return zero outside their own range, so OR merges them
	always_ff @(posedge o_clk) begin
		if (o_resetn == 1'b0) begin
			o_rd_data <= '0;
		end else if (i_rd_en) begin
			if (i_rd_idx == REG_VERSION) begin
				o_rd_data <= CORE_VERSION;
			end else begin
				o_rd_data <= i_ctl_word | i_s1_word | i_s2_word;
			end
		end
	end

endmodule

/* display_ctl.sv */
`timescale 1ns/1ps

module display_ctl import fsctl_pkg::*; (
	input  logic      o_clk,
	input  logic      o_resetn,
	input  logic      i_fsync_rise,
	cfg_bus_if.target bus,
	output reg_data_t o_rd_word,
	output logic      o_apply_cfg,
	output logic      o_soft_resetn,
	output logic      o_order_1over2,
	output logic      o_s0_soft_resetn,
	output logic      o_s1_soft_resetn,
	output logic      o_s2_soft_resetn
);

	logic       cfging;
	logic       stg_order;
	logic [2:0] stg_running;

	// ----------------------------------------------------------------------
	// register 0 and staged register 1
	// ----------------------------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (o_resetn == 1'b0) begin
			o_soft_resetn <= 1'b0;
			cfging        <= 1'b0;
			stg_order     <= 1'b0;
			stg_running   <= RUNNING_RESET;
		end else if (bus.wr_en) begin
			if (bus.wr_idx == REG_CTRL) begin
				o_soft_resetn <= bus.wr_data[0];
				cfging        <= bus.wr_data[1];
			end
			if (bus.wr_idx == REG_DISP) begin
				stg_order   <= bus.wr_data[0];
				stg_running <= bus.wr_data[3:1];
			end
		end
	end

	// host holds off the update while it is still configuring
	assign o_apply_cfg = i_fsync_rise & ~cfging;

	// ----------------------------------------------------------------------
	// applied settings
	// ----------------------------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (o_resetn == 1'b0) begin
			o_order_1over2   <= 1'b0;
			o_s0_soft_resetn <= 1'b0;
			o_s1_soft_resetn <= 1'b0;
			o_s2_soft_resetn <= 1'b0;
		end else if (o_apply_cfg) begin
			o_order_1over2   <= stg_order;
			o_s0_soft_resetn <= stg_running[0];
			o_s1_soft_resetn <= stg_running[1];
			o_s2_soft_resetn <= stg_running[2];
		end
	end

	// readback of staged values
	always_comb begin
		o_rd_word = '0;
		case (bus.rd_idx)
			REG_CTRL: o_rd_word = reg_data_t'({cfging, o_soft_resetn});
			REG_DISP: o_rd_word = reg_data_t'({stg_running, stg_order});
			default:  o_rd_word = '0;
		endcase
	end

	// edge detector upstream must never give back-to-back rises
	a_apply_single: assert property (
		@(posedge o_clk) disable iff (o_resetn == 1'b0)
		o_apply_cfg |=> !o_apply_cfg
	);

endmodule

/* frame_sync_detect.sv */
`timescale 1ns/1ps

module frame_sync_detect (
	input  logic o_clk,
	input  logic o_resetn,
	input  logic i_fsync,
	output logic o_fsync_rise,
	output logic o_fsync
);

	logic fsync_d1;
	logic fsync_d2;

	// two stage synchronizer
	always_ff @(posedge o_clk) begin
		if (o_resetn == 1'b0) begin
			fsync_d1 <= 1'b0;
			fsync_d2 <= 1'b0;
		end else begin
			fsync_d1 <= i_fsync;
			fsync_d2 <= fsync_d1;
		end
	end

	assign o_fsync_rise = fsync_d1 & ~fsync_d2;

	// one cycle behind the rise, lines up with the applied settings
	always_ff @(posedge o_clk) begin
		if (o_resetn == 1'b0) begin
			o_fsync <= 1'b0;
		end else begin
			o_fsync <= o_fsync_rise;
		end
	end

endmodule

/* fsctl_pkg.sv */
package fsctl_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int DATA_W     = 32;
	localparam int IDX_W      = 8;
	localparam int IMG_W_BITS = 12;
	localparam int IMG_H_BITS = 12;

	typedef logic [DATA_W-1:0]     reg_data_t;
	typedef logic [IDX_W-1:0]      reg_idx_t;
	typedef logic [IMG_W_BITS-1:0] img_w_t;
	typedef logic [IMG_H_BITS-1:0] img_h_t;

	// ----------------------------------------------------------------------
	// register map
	// ----------------------------------------------------------------------
	localparam reg_idx_t REG_CTRL    = 8'd0;
	localparam reg_idx_t REG_DISP    = 8'd1;
	localparam reg_idx_t REG_S1_BASE = 8'd2;
	localparam reg_idx_t REG_S2_BASE = 8'd7;
	localparam reg_idx_t REG_VERSION = 8'd255;

	localparam reg_data_t CORE_VERSION = 32'hFF00FF00;

	// geometry words: width/left in the low field, height/top in the high field
	localparam int GEOM_REGS  = 5;
	localparam int GEOM_SEL_W = $clog2(GEOM_REGS);
	localparam int GEOM_H_LSB = 16;

	// stream 0 running, streams 1 and 2 stopped
	localparam logic [2:0] RUNNING_RESET = 3'b001;

endpackage

/* fsctl_top.sv */
`timescale 1ns/1ps

module fsctl_top import fsctl_pkg::*; (
	input  logic      o_clk,
	input  logic      o_resetn,
	input  logic      i_wr_en,
	input  reg_idx_t  i_wr_idx,
	input  reg_data_t i_wr_data,
	input  logic      i_rd_en,
	input  reg_idx_t  i_rd_idx,
	input  logic      i_fsync,
	output reg_data_t o_rd_data,
	output logic      o_fsync,
	output logic      o_soft_resetn,
	output logic      o_order_1over2,
	output logic      o_s0_soft_resetn,
	output logic      o_s1_soft_resetn,
	output logic      o_s2_soft_resetn,
	// stream 1
	output img_w_t    o_s1_width,
	output img_h_t    o_s1_height,
	output img_w_t    o_s1_win_left,
	output img_h_t    o_s1_win_top,
	output img_w_t    o_s1_win_width,
	output img_h_t    o_s1_win_height,
	output img_w_t    o_s1_dst_left,
	output img_h_t    o_s1_dst_top,
	output img_w_t    o_s1_dst_width,
	output img_h_t    o_s1_dst_height,
	// stream 2
	output img_w_t    o_s2_width,
	output img_h_t    o_s2_height,
	output img_w_t    o_s2_win_left,
	output img_h_t    o_s2_win_top,
	output img_w_t    o_s2_win_width,
	output img_h_t    o_s2_win_height,
	output img_w_t    o_s2_dst_left,
	output img_h_t    o_s2_dst_top,
	output img_w_t    o_s2_dst_width,
	output img_h_t    o_s2_dst_height
);

	logic      fsync_rise;
	logic      apply_cfg;
	reg_data_t ctl_word;
	reg_data_t s1_word;
	reg_data_t s2_word;

	cfg_bus_if bus ();

	assign bus.wr_en   = i_wr_en;
	assign bus.wr_idx  = i_wr_idx;
	assign bus.wr_data = i_wr_data;
	assign bus.rd_idx  = i_rd_idx;

	frame_sync_detect u_fsync (
		.o_clk        (o_clk),
		.o_resetn     (o_resetn),
		.i_fsync      (i_fsync),
		.o_fsync_rise (fsync_rise),
		.o_fsync      (o_fsync)
	);

	display_ctl u_disp (
		.o_clk            (o_clk),
		.o_resetn         (o_resetn),
		.i_fsync_rise     (fsync_rise),
		.bus              (bus.target),
		.o_rd_word        (ctl_word),
		.o_apply_cfg      (apply_cfg),
		.o_soft_resetn    (o_soft_resetn),
		.o_order_1over2   (o_order_1over2),
		.o_s0_soft_resetn (o_s0_soft_resetn),
		.o_s1_soft_resetn (o_s1_soft_resetn),
		.o_s2_soft_resetn (o_s2_soft_resetn)
	);

	stream_geom_regs #(.STREAM_BASE(REG_S1_BASE)) u_s1_geom (
		.o_clk        (o_clk),
		.o_resetn     (o_resetn),
		.i_apply_cfg  (apply_cfg),
		.bus          (bus.target),
		.o_rd_word    (s1_word),
		.o_width      (o_s1_width),
		.o_height     (o_s1_height),
		.o_win_left   (o_s1_win_left),
		.o_win_top    (o_s1_win_top),
		.o_win_width  (o_s1_win_width),
		.o_win_height (o_s1_win_height),
		.o_dst_left   (o_s1_dst_left),
		.o_dst_top    (o_s1_dst_top),
		.o_dst_width  (o_s1_dst_width),
		.o_dst_height (o_s1_dst_height)
	);

	stream_geom_regs #(.STREAM_BASE(REG_S2_BASE)) u_s2_geom (
		.o_clk        (o_clk),
		.o_resetn     (o_resetn),
		.i_apply_cfg  (apply_cfg),
		.bus          (bus.target),
		.o_rd_word    (s2_word),
		.o_width      (o_s2_width),
		.o_height     (o_s2_height),
		.o_win_left   (o_s2_win_left),
		.o_win_top    (o_s2_win_top),
		.o_win_width  (o_s2_win_width),
		.o_win_height (o_s2_win_height),
		.o_dst_left   (o_s2_dst_left),
		.o_dst_top    (o_s2_dst_top),
		.o_dst_width  (o_s2_dst_width),
		.o_dst_height (o_s2_dst_height)
	);

	cfg_read_port u_rd (
		.o_clk      (o_clk),
		.o_resetn   (o_resetn),
		.i_rd_en    (i_rd_en),
		.i_rd_idx   (i_rd_idx),
		.i_ctl_word (ctl_word),
		.i_s1_word  (s1_word),
		.i_s2_word  (s2_word),
		.o_rd_data  (o_rd_data)
	);

endmodule

/* sim.f */
fsctl_pkg.sv
cfg_bus_if.sv
frame_sync_detect.sv
display_ctl.sv
stream_geom_regs.sv
cfg_read_port.sv
fsctl_top.sv
tb_fsctl.sv

/* stream_geom_regs.sv */
`timescale 1ns/1ps

module stream_geom_regs import fsctl_pkg::*; #(
	parameter reg_idx_t STREAM_BASE = REG_S1_BASE
) (
	input  logic      o_clk,
	input  logic      o_resetn,
	input  logic      i_apply_cfg,
	cfg_bus_if.target bus,
	output reg_data_t o_rd_word,
	output img_w_t    o_width,
	output img_h_t    o_height,
	output img_w_t    o_win_left,
	output img_h_t    o_win_top,
	output img_w_t    o_win_width,
	output img_h_t    o_win_height,
	output img_w_t    o_dst_left,
	output img_h_t    o_dst_top,
	output img_w_t    o_dst_width,
	output img_h_t    o_dst_height
);

	img_w_t [GEOM_REGS-1:0] stg_w;
	img_h_t [GEOM_REGS-1:0] stg_h;
	img_w_t [GEOM_REGS-1:0] app_w;
	img_h_t [GEOM_REGS-1:0] app_h;

	reg_idx_t              wr_off;
	reg_idx_t              rd_off;
	logic                  wr_hit;
	logic                  rd_hit;
	logic [GEOM_SEL_W-1:0] wr_sel;
	logic [GEOM_SEL_W-1:0] rd_sel;

	// indices below the base wrap around and miss
	assign wr_off = bus.wr_idx - STREAM_BASE;
	assign rd_off = bus.rd_idx - STREAM_BASE;
	assign wr_hit = bus.wr_en && (wr_off < GEOM_REGS);
	assign rd_hit = (rd_off < GEOM_REGS);
	assign wr_sel = wr_off[GEOM_SEL_W-1:0];
	assign rd_sel = rd_off[GEOM_SEL_W-1:0];

	// ----------------------------------------------------------------------
	// staged words
	// ----------------------------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (o_resetn == 1'b0) begin
			stg_w <= '0;
			stg_h <= '0;
		end else if (wr_hit) begin
			stg_w[wr_sel] <= bus.wr_data[IMG_W_BITS-1:0];
			stg_h[wr_sel] <= bus.wr_data[GEOM_H_LSB +: IMG_H_BITS];
		end
	end

	// copied once per frame
	always_ff @(posedge o_clk) begin
		if (o_resetn == 1'b0) begin
			app_w <= '0;
			app_h <= '0;
		end else if (i_apply_cfg) begin
			app_w <= stg_w;
			app_h <= stg_h;
		end
	end

	always_comb begin
		o_rd_word = '0;
		if (rd_hit) begin
			o_rd_word[IMG_W_BITS-1:0]          = stg_w[rd_sel];
			o_rd_word[GEOM_H_LSB +: IMG_H_BITS] = stg_h[rd_sel];
		end
	end

	// ----------------------------------------------------------------------
	// register order: size, window pos, window size, dest pos, dest size
	// ----------------------------------------------------------------------
	assign o_width      = app_w[0];
	assign o_height     = app_h[0];
	assign o_win_left   = app_w[1];
	assign o_win_top    = app_h[1];
	assign o_win_width  = app_w[2];
	assign o_win_height = app_h[2];
	assign o_dst_left   = app_w[3];
	assign o_dst_top    = app_h[3];
	assign o_dst_width  = app_w[4];
	assign o_dst_height = app_h[4];

	// geometry only moves on a frame boundary
	a_apply_only: assert property (
		@(posedge o_clk) disable iff (o_resetn == 1'b0)
		!($stable(app_w) && $stable(app_h)) |-> $past(i_apply_cfg)
	);

endmodule

/* tb_fsctl.sv */
`timescale 1ns/1ps

module tb_fsctl import fsctl_pkg::*; ();

	// rough cycle budget: reset, then tests 1 to 5
	localparam int TEST_CYCLES = 8 + 6 + 54 + 34 + 38 + 4;
	localparam int MAX_CYCLES  = 2 * TEST_CYCLES;
	localparam int NUM_KEPT    = 12;

	logic      o_clk;
	logic      o_resetn;
	logic      i_wr_en;
	reg_idx_t  i_wr_idx;
	reg_data_t i_wr_data;
	logic      i_rd_en;
	reg_idx_t  i_rd_idx;
	logic      i_fsync;
	reg_data_t o_rd_data;
	logic      o_fsync, o_soft_resetn, o_order_1over2;
	logic      o_s0_soft_resetn, o_s1_soft_resetn, o_s2_soft_resetn;
	img_w_t    o_s1_width, o_s1_win_left, o_s1_win_width, o_s1_dst_left, o_s1_dst_width;
	img_h_t    o_s1_height, o_s1_win_top, o_s1_win_height, o_s1_dst_top, o_s1_dst_height;
	img_w_t    o_s2_width, o_s2_win_left, o_s2_win_width, o_s2_dst_left, o_s2_dst_width;
	img_h_t    o_s2_height, o_s2_win_top, o_s2_win_height, o_s2_dst_top, o_s2_dst_height;

	// staged register images and applied outputs of the model
	reg_data_t   stg_mem [0:NUM_KEPT-1];
	reg_data_t   app_geom [0:9];
	logic [3:0]  app_disp;
	logic        exp_fsync;
	reg_data_t   lcg_state = 32'd95588;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          cycles = 0;
	int          test_err_base = 0;
	logic [245:0] dut_out;

	fsctl_top UUT (.*);

	assign dut_out = {o_fsync, o_soft_resetn, o_order_1over2,
		o_s0_soft_resetn, o_s1_soft_resetn, o_s2_soft_resetn,
		o_s2_dst_height, o_s2_dst_width, o_s2_dst_top, o_s2_dst_left,
		o_s2_win_height, o_s2_win_width, o_s2_win_top, o_s2_win_left,
		o_s2_height, o_s2_width,
		o_s1_dst_height, o_s1_dst_width, o_s1_dst_top, o_s1_dst_left,
		o_s1_win_height, o_s1_win_width, o_s1_win_top, o_s1_win_left,
		o_s1_height, o_s1_width};

	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

	function automatic reg_data_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// fields defined by the register layout
	function automatic reg_data_t field_mask(input int idx);
		if (idx == 0)
			return 32'h0000_0003;
		else if (idx == 1)
			return 32'h0000_000f;
		else if (idx < NUM_KEPT)
			return 32'h0fff_0fff;
		return '0;
	endfunction

	function automatic reg_data_t expect_read(input int idx);
		if (idx == REG_VERSION)
			return CORE_VERSION;
		else if (idx < NUM_KEPT)
			return stg_mem[idx];
		return '0;
	endfunction

	function automatic logic [245:0] expect_outputs();
		logic [245:0] v;
		v[245:240] = {exp_fsync, stg_mem[0][0], app_disp[0], app_disp[1],
			app_disp[2], app_disp[3]};
		for (int k = 0; k < 10; k++)
			v[k*24 +: 24] = {app_geom[k][27:16], app_geom[k][11:0]};
		return v;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < NUM_KEPT; i++)
			stg_mem[i] = '0;
		stg_mem[1] = reg_data_t'({RUNNING_RESET, 1'b0});
		for (int k = 0; k < 10; k++)
			app_geom[k] = '0;
		app_disp  = '0;
		exp_fsync = 1'b0;
	endtask

	task automatic write_reg(input int idx, input reg_data_t data);
		@(posedge o_clk);
		#1;
		i_wr_en   = 1'b1;
		i_wr_idx  = reg_idx_t'(idx);
		i_wr_data = data;
		@(posedge o_clk);
		#1;
		i_wr_en = 1'b0;
		if (idx < NUM_KEPT)
			stg_mem[idx] = data & field_mask(idx);
	endtask

	task automatic read_check(input int idx);
		@(posedge o_clk);
		#1;
		i_rd_en  = 1'b1;
		i_rd_idx = reg_idx_t'(idx);
		@(posedge o_clk);
		#1;
		i_rd_en = 1'b0;
		checks++;
		assert (o_rd_data === expect_read(idx)) else begin
			$display("mismatch at %0t: reg %0d read %h, expected %h",
				$time, idx, o_rd_data, expect_read(idx));
			errors++;
		end
	endtask

	// rise seen after the first edge, apply and o_fsync on the second
	task automatic pulse_fsync();
		@(posedge o_clk);
		#1;
		i_fsync = 1'b1;
		repeat (2) @(posedge o_clk);
		#1;
		exp_fsync = 1'b1;
		if (stg_mem[0][1] == 1'b0) begin
			app_disp = stg_mem[1][3:0];
			for (int k = 0; k < 10; k++)
				app_geom[k] = stg_mem[2 + k];
		end
		checks++;
		assert (o_fsync === 1'b1) else begin
			$display("mismatch at %0t: o_fsync low on the apply edge", $time);
			errors++;
		end
		@(posedge o_clk);
		#1;
		exp_fsync = 1'b0;
		i_fsync   = 1'b0;
		repeat (2) @(posedge o_clk);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s (%0d errors)", tests, name,
			(errors == test_err_base) ? "ok" : "failed", errors - test_err_base);
		test_err_base = errors;
	endtask

	// ----------------------------------------------------------------------
	// compare outputs mid cycle
	// ----------------------------------------------------------------------
	always @(negedge o_clk) begin
		if (o_resetn) begin
			checks++;
			assert (dut_out === expect_outputs()) else begin
				$display("mismatch at %0t: outputs %h, expected %h",
					$time, dut_out, expect_outputs());
				errors++;
			end
		end
	end

	initial begin
		while (cycles < MAX_CYCLES) begin
			@(posedge o_clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		o_resetn  = 1'b0;
		i_wr_en   = 1'b0;
		i_wr_idx  = '0;
		i_wr_data = '0;
		i_rd_en   = 1'b0;
		i_rd_idx  = '0;
		i_fsync   = 1'b0;
		model_reset();
		repeat (8) @(posedge o_clk);
		#1;
		o_resetn = 1'b1;

		read_check(REG_CTRL);
		read_check(REG_DISP);
		read_check(REG_VERSION);
		end_test("reset state");

		for (int i = 0; i < NUM_KEPT; i++)
			write_reg(i, next_rand());
		for (int i = 0; i < NUM_KEPT; i++)
			read_check(i);
		read_check(12);
		read_check(100);
		read_check(254);
		end_test("readback");

		write_reg(REG_CTRL, 32'h1);
		write_reg(REG_DISP, next_rand());
		for (int i = 2; i < NUM_KEPT; i++)
			write_reg(i, next_rand());
		repeat (4) @(posedge o_clk);
		pulse_fsync();
		end_test("staging");

		// configuring bit set, frame sync must not apply
		write_reg(REG_CTRL, 32'h3);
		for (int i = 1; i < NUM_KEPT; i++)
			write_reg(i, next_rand());
		pulse_fsync();
		write_reg(REG_CTRL, 32'h1);
		pulse_fsync();
		end_test("hold-off");

		write_reg(REG_CTRL, 32'h0);
		checks++;
		assert (o_soft_resetn === 1'b0) else begin
			$display("mismatch at %0t: o_soft_resetn not cleared by write", $time);
			errors++;
		end
		write_reg(REG_CTRL, 32'h1);
		checks++;
		assert (o_soft_resetn === 1'b1) else begin
			$display("mismatch at %0t: o_soft_resetn not set by write", $time);
			errors++;
		end
		end_test("direct bit");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
